//--- logic/Alu.sv
`default_nettype none

module Alu (
    input  mipsPkg::opcode_e                   aluOp,
    input  wire logic [5:0]                    funct,
    input  wire logic [mipsPkg::DataWidth-1:0] a,
    input  wire logic [mipsPkg::DataWidth-1:0] b,
    output logic      [mipsPkg::DataWidth-1:0] result,
    output logic                               zero,
    output logic                               negative
);
    import mipsPkg::*;

    logic                 lessThan;
    logic [DataWidth-1:0] sltWord;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);
    assign sltWord  = {{(DataWidth-1){1'b0}}, lessThan};

    always_comb begin
        result = '0;

        case (aluOp)
            opRType: begin
                case (funct_e'(funct))
                    fnAdd:   result = a + b;
                    fnSub:   result = a - b;
                    fnAnd:   result = a & b;
                    fnOr:    result = a | b;
                    fnXor:   result = a ^ b;
                    fnSlt:   result = sltWord;
                    default: result = '0;         // Unknown funct
                endcase
            end

            // Address and addi arithmetic
            opAddi, opLw, opSw: result = a + b;

            opAndi: result = a & b;
            opOri:  result = a | b;
            opXori: result = a ^ b;

            opBeq, opBne: result = a - b;         // Zero when equal

            // Compare-with-zero branches, flags follow rs
            opBlez, opBgtz, opRegImm: result = a;

            default: result = '0;                 // j and no-ops
        endcase
    end

    // Flags for the branch unit
    assign zero     = (result == '0);
    assign negative = result[DataWidth-1];

endmodule

`default_nettype wire

//--- logic/BranchUnit.sv
`default_nettype none

module BranchUnit (
    input  wire logic                          Clk,
    input  wire logic                          rst,
    input  wire logic                          branch,
    input  wire logic                          jump,
    input  mipsPkg::opcode_e                   branchOp,
    input  wire logic [4:0]                    rtField,
    input  wire logic                          zero,
    input  wire logic                          negative,
    input  wire logic [mipsPkg::DataWidth-1:0] offset,
    input  wire logic [25:0]                   target,
    output logic      [mipsPkg::DataWidth-1:0] pc
);
    import mipsPkg::*;

    logic                 cond;
    logic                 taken;
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] nextPc;

    // Branch condition from the ALU flags
    always_comb begin
        case (branchOp)
            opBeq:    cond = zero;
            opBne:    cond = !zero;
            opBlez:   cond = negative || zero;
            opBgtz:   cond = !negative && !zero;
            opRegImm: cond = (rtField == 5'd0) ? negative        // bltz
                           : (rtField == 5'd1) ? !negative       // bgez
                           : 1'b0;
            default:  cond = 1'b0;
        endcase
    end

    assign taken   = branch && cond;
    assign pcPlus4 = pc + 32'd4;

    // Jump wins, then branch, else sequential
    always_comb begin
        if (jump)
            nextPc = {pcPlus4[31:28], target, 2'b00};
        else if (taken)
            nextPc = pcPlus4 + {offset[DataWidth-3:0], 2'b00};   // Word offset
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge Clk) begin
        if (rst) pc <= '0;
        else     pc <= nextPc;
    end

endmodule

`default_nettype wire

//--- logic/Controller.sv
`default_nettype none

module Controller (
    input  wire logic [mipsPkg::DataWidth-1:0] instruction,
    output mipsPkg::ctrl_t                     ctrl
);
    import mipsPkg::*;

    opcode_e op;

    // Opcode field, unknown values fall to default
    assign op = opcode_e'(instruction[31:26]);

    always_comb begin
        ctrl = '0;                        // Everything inactive first

        case (op)
            opRType: begin
                ctrl.aluOp    = op;
                ctrl.regDst   = 1'b1;     // Result to rd
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            opAddi: begin
                ctrl.aluOp    = op;
                ctrl.aluSrc   = 1'b1;     // Sign-extended imm
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            // Logical immediates
            opAndi, opOri, opXori: begin
                ctrl.aluOp    = op;
                ctrl.aluSrc   = 1'b1;
                ctrl.zeroExt  = 1'b1;     // Upper half cleared
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            opLw: begin
                ctrl.aluOp    = op;
                ctrl.aluSrc   = 1'b1;     // base + offset
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;     // memtoReg stays 0, load data
            end

            opSw: begin
                ctrl.aluOp    = op;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;     // No register write
            end

            // Compare forms, B stays rt so beq/bne can subtract
            opBeq, opBne, opBlez, opBgtz, opRegImm: begin
                ctrl.aluOp  = op;
                ctrl.branch = 1'b1;
            end

            opJ: begin
                ctrl.aluOp = op;
                ctrl.jump  = 1'b1;        // Pseudo-direct target
            end

            default: begin
                // Unsupported, acts as a no-op
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/MipsCore.sv
`default_nettype none

module MipsCore (
    input  wire logic                          Clk,
    input  wire logic                          rst,
    input  wire logic [mipsPkg::DataWidth-1:0] instruction,
    input  wire logic [mipsPkg::DataWidth-1:0] readData,
    output logic      [mipsPkg::DataWidth-1:0] pc,
    output mipsPkg::dataBus_t                  dataBus
);
    import mipsPkg::*;

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////

    logic [RegAddrWidth-1:0] rs, rt, rd;
    logic [15:0]             imm;

    assign rs  = instruction[25:21];
    assign rt  = instruction[20:16];
    assign rd  = instruction[15:11];
    assign imm = instruction[15:0];

    ctrl_t                   ctrl;
    logic [DataWidth-1:0]    rsData;
    logic [DataWidth-1:0]    rtData;
    logic [DataWidth-1:0]    extImm;
    logic [DataWidth-1:0]    aluB;
    logic [DataWidth-1:0]    aluResult;
    logic                    zero;
    logic                    negative;
    logic [RegAddrWidth-1:0] writeReg;
    logic [DataWidth-1:0]    writeBack;

    // Decode
    Controller u_controller (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    RegisterFile u_regFile (
        .Clk         (Clk),
        .rst         (rst),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .readDataA   (rsData),
        .readDataB   (rtData),
        .writeEnable (ctrl.regWrite),
        .writeAddr   (writeReg),
        .writeData   (writeBack)
    );

    ////////////////////////////////////////
    // Operand muxes and execute
    ////////////////////////////////////////

    // Zero-extend andi/ori/xori, sign-extend the rest
    assign extImm   = ctrl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign aluB     = ctrl.aluSrc ? extImm : rtData;
    assign writeReg = ctrl.regDst ? rd : rt;                 // rd for R-type

    Alu u_alu (
        .aluOp    (ctrl.aluOp),
        .funct    (instruction[5:0]),
        .a        (rsData),
        .b        (aluB),
        .result   (aluResult),
        .zero     (zero),
        .negative (negative)
    );

    ////////////////////////////////////////
    // Memory and write-back
    ////////////////////////////////////////

    // Strobes held low while in reset
    assign dataBus.addr      = aluResult;
    assign dataBus.writeData = rtData;
    assign dataBus.read      = ctrl.memRead && !rst;
    assign dataBus.write     = ctrl.memWrite && !rst;

    assign writeBack = ctrl.memtoReg ? aluResult : readData; // 0 = load

    // Next PC
    BranchUnit u_branch (
        .Clk      (Clk),
        .rst      (rst),
        .branch   (ctrl.branch),
        .jump     (ctrl.jump),
        .branchOp (ctrl.aluOp),
        .rtField  (rt),
        .zero     (zero),
        .negative (negative),
        .offset   (extImm),
        .target   (instruction[25:0]),
        .pc       (pc)
    );

endmodule

`default_nettype wire

//--- logic/RegisterFile.sv
`default_nettype none

module RegisterFile (
    input  wire logic                                 Clk,
    input  wire logic                                 rst,
    input  wire logic [mipsPkg::RegAddrWidth-1:0]     readAddrA,
    input  wire logic [mipsPkg::RegAddrWidth-1:0]     readAddrB,
    output logic      [mipsPkg::DataWidth-1:0]        readDataA,
    output logic      [mipsPkg::DataWidth-1:0]        readDataB,
    input  wire logic                                 writeEnable,
    input  wire logic [mipsPkg::RegAddrWidth-1:0]     writeAddr,
    input  wire logic [mipsPkg::DataWidth-1:0]        writeData
);
    import mipsPkg::*;

    // Entries 1..31, register zero has no storage
    logic [DataWidth-1:0] regs [1:(1 << RegAddrWidth)-1];

    // Combinational reads
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 1; i < (1 << RegAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;         // $zero writes dropped
        end
    end

endmodule

`default_nettype wire

//--- logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

    ////////////////////////////////////////
    // Fixed widths
    ////////////////////////////////////////

    localparam int DataWidth    = 32;     // Data and address width
    localparam int RegAddrWidth = 5;      // 32 registers

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        opRType  = 6'b000000,
        opRegImm = 6'b000001,             // bltz / bgez, picked by rt
        opJ      = 6'b000010,
        opBeq    = 6'b000100,
        opBne    = 6'b000101,
        opBlez   = 6'b000110,
        opBgtz   = 6'b000111,
        opAddi   = 6'b001000,
        opAndi   = 6'b001100,
        opOri    = 6'b001101,
        opXori   = 6'b001110,
        opLw     = 6'b100011,
        opSw     = 6'b101011
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnXor = 6'b100110,
        fnSlt = 6'b101010
    } funct_e;

    ////////////////////////////////////////
    // Decoded controls
    ////////////////////////////////////////

    typedef struct packed {
        logic    regDst;                  // Write rd instead of rt
        opcode_e aluOp;                   // Raw opcode, ALU decodes further
        logic    aluSrc;                  // B operand is the immediate
        logic    branch;
        logic    jump;
        logic    memRead;
        logic    memWrite;
        logic    memtoReg;                // 1 = ALU result, 0 = load data
        logic    regWrite;
        logic    zeroExt;                 // Logical immediates only
    } ctrl_t;

    ////////////////////////////////////////
    // Data port, core to memory
    ////////////////////////////////////////

    typedef struct packed {
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] writeData;  // rt value for sw
        logic                 read;
        logic                 write;      // One-cycle strobe per store
    } dataBus_t;

endpackage

`default_nettype wire

//--- project.f
logic/mipsPkg.sv
logic/Controller.sv
logic/Alu.sv
logic/RegisterFile.sv
logic/BranchUnit.sv
logic/MipsCore.sv
testbench/mipsCore_checker.sv
testbench/tbMipsCore.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, then decide from the log
verilator --binary --timing --assert --top-module tbMipsCore -f project.f -o simTb \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/simTb > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

//--- testbench/mipsCore_checker.sv
`default_nettype none

module mipsCore_checker (
    input wire logic                          Clk,
    input wire logic                          rst,
    input wire logic [mipsPkg::DataWidth-1:0] pc,
    input mipsPkg::dataBus_t                  dataBus
);
    import mipsPkg::*;

    // Never load and store at once
    assert property (@(posedge Clk) !(dataBus.read && dataBus.write))
        else $error("data port read and write high together");

    assert property (@(posedge Clk) pc[1:0] == 2'b00)    // Word fetches only
        else $error("pc not word aligned");

    // No stray store right out of reset
    assert property (@(posedge Clk) rst |=> !dataBus.write)
        else $error("store strobe in the cycle after reset");

endmodule

bind MipsCore mipsCore_checker u_checker (
    .Clk     (Clk),
    .rst     (rst),
    .pc      (pc),
    .dataBus (dataBus)
);

`default_nettype wire

//--- testbench/tbMipsCore.sv
`default_nettype none

module tbMipsCore;
    import mipsPkg::*;

    logic        Clk;
    logic        rst;
    logic [31:0] pc;
    dataBus_t    dataBus;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] stAddr[$], stData[$], stPc[$];
    integer      seed = 32'h43d9_fc8f;
    int          idx;

    // Both memories answer in the same cycle
    // Data memory drives readData only while read is high
    MipsCore u_dut (
        .Clk         (Clk),
        .rst         (rst),
        .instruction (imem[pc[9:2]]),
        .readData    (dataBus.read ? dmem[dataBus.addr[9:2]] : 32'h0),
        .pc          (pc),
        .dataBus     (dataBus)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // Store strobe monitor sees pre-edge values
    always @(posedge Clk) begin
        if (dataBus.write) begin
            dmem[dataBus.addr[9:2]] = dataBus.writeData;
            stAddr.push_back(dataBus.addr);
            stData.push_back(dataBus.writeData);
            stPc.push_back(pc);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] iWord(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] rWord(int rs, int rt, int rd, funct_e fn);
        return {opRType, rs[4:0], rt[4:0], rd[4:0], 5'b00000, fn};
    endfunction

    function automatic logic [31:0] sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic fail(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkEq(logic [31:0] got, logic [31:0] exp, string what);
        assert (got === exp) else begin
            $display("Error at time %0t: %s got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic emit(logic [31:0] w);
        imem[idx] = w;
        idx++;
    endtask

    // Hold reset, wipe program and store log
    task automatic beginProgram();
        @(posedge Clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;                      // nop
            dmem[i] = 32'hA500_0000 ^ (i * 4);    // Address-based fill
        end
        stAddr.delete();
        stData.delete();
        stPc.delete();
        idx = 0;
    endtask

    // Appends end marker store and runs until it is seen
    task automatic runProgram();
        int cycles;
        emit(iWord(opSw, 0, 0, 16'h03FC));
        repeat (5) @(posedge Clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (stAddr.size() == 0 || stAddr[$] != 32'h3FC) begin
            @(posedge Clk);
            #1 cycles++;
            if (cycles > 200) fail("Timeout waiting for the end-of-program store");
        end
    endtask

    task automatic expectStore(logic [31:0] addr, logic [31:0] data, logic [31:0] pcExp);
        assert (stAddr.size() != 0) else fail("A store was expected but none happened");
        checkEq(stAddr.pop_front(), addr, "store address");
        checkEq(stData.pop_front(), data, "store data");
        checkEq(stPc.pop_front(), pcExp, "pc of store");
    endtask

    task automatic finishCheck();
        expectStore(32'h3FC, 32'h0, (idx - 1) * 4);
        assert (stAddr.size() == 0)
            else fail("Unexpected extra store after the program end");
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic testReset();
        beginProgram();
        imem[0] = iWord(opSw, 0, 0, 16'h0010);      // Store held off by reset
        repeat (5) begin
            @(posedge Clk);
            #1 checkEq(pc, 32'h0, "pc in reset");
        end
        imem[0] = 32'h0;                            // Back to nop before release
        rst = 1'b0;
        for (int k = 0; k < 8; k++) begin
            checkEq(pc, k * 4, "pc through nops");
            @(posedge Clk);
            #1;
        end
        assert (stAddr.size() == 0)
            else fail("Store strobe seen during reset or while running nops");
    endtask

    task automatic testImmediates();
        logic [31:0] a;
        logic [15:0] immN, immL;
        beginProgram();
        a    = $random(seed);
        immN = 16'h8000 | 16'($random(seed));      // Negative addi imm
        immL = 16'h8000 | 16'($random(seed));      // Top bit set
        dmem[16] = a;
        emit(iWord(opLw, 0, 1, 16'h0040));
        emit(iWord(opAddi, 1, 2, immN));
        emit(iWord(opAndi, 1, 3, immL));
        emit(iWord(opOri, 1, 4, immL));
        emit(iWord(opXori, 1, 5, immL));
        for (int r = 2; r <= 5; r++) begin
            emit(iWord(opSw, 0, r, 16'(16'h0100 + (r - 2) * 4)));
        end
        runProgram();
        expectStore(32'h100, a + sext(immN), 20);
        expectStore(32'h104, a & {16'h0, immL}, 24);
        expectStore(32'h108, a | {16'h0, immL}, 28);
        expectStore(32'h10C, a ^ {16'h0, immL}, 32);
        finishCheck();
    endtask

    task automatic testRType();
        logic [31:0] a, b;
        logic [31:0] exp [0:6];
        beginProgram();
        a = $random(seed);
        b = $random(seed);
        if (a == b) b = a + 1;                      // Both slt outcomes
        dmem[16] = a;
        dmem[17] = b;
        emit(iWord(opLw, 0, 1, 16'h0040));
        emit(iWord(opLw, 0, 2, 16'h0044));
        emit(rWord(1, 2, 3, fnAdd));
        emit(rWord(1, 2, 4, fnSub));
        emit(rWord(1, 2, 5, fnAnd));
        emit(rWord(1, 2, 6, fnOr));
        emit(rWord(1, 2, 7, fnXor));
        emit(rWord(1, 2, 8, fnSlt));
        emit(rWord(2, 1, 9, fnSlt));
        emit(rWord(1, 2, 0, fnAdd));                // Dropped write to $zero
        for (int r = 3; r <= 9; r++) begin
            emit(iWord(opSw, 0, r, 16'(16'h0100 + (r - 3) * 4)));
        end
        emit(iWord(opSw, 0, 0, 16'h0120));
        exp[0] = a + b;
        exp[1] = a - b;
        exp[2] = a & b;
        exp[3] = a | b;
        exp[4] = a ^ b;
        exp[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exp[6] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        runProgram();
        for (int k = 0; k < 7; k++) expectStore(32'h100 + k * 4, exp[k], 40 + k * 4);
        expectStore(32'h120, 32'h0, 68);
        finishCheck();
    endtask

    task automatic testLoad();
        logic [31:0] v;
        beginProgram();
        v = $random(seed);
        dmem[128] = v;                              // Address 0x200
        emit(iWord(opOri, 0, 6, 16'h0208));
        emit(iWord(opLw, 6, 7, 16'hFFF8));          // 0x208 - 8
        emit(iWord(opSw, 0, 7, 16'h0300));
        runProgram();
        expectStore(32'h300, v, 8);
        finishCheck();
    endtask

    // Fall-through store at 12 and target store at 20
    task automatic branchCase(opcode_e op, int rtSel, logic [31:0] a, logic [31:0] b, bit taken);
        beginProgram();
        dmem[16] = a;
        dmem[17] = b;
        emit(iWord(opLw, 0, 1, 16'h0040));
        emit(iWord(opLw, 0, 2, 16'h0044));
        emit(iWord(op, 1, rtSel, 16'h0002));
        emit(iWord(opSw, 0, 0, 16'h0400));
        emit(32'h0);
        emit(iWord(opSw, 0, 0, 16'h0404));
        runProgram();
        if (!taken) expectStore(32'h400, 32'h0, 12);
        expectStore(32'h404, 32'h0, 20);
        finishCheck();
    endtask

    task automatic testBranches();
        logic [31:0] a;
        a = $random(seed);
        branchCase(opBeq, 2, a, a, 1'b1);
        branchCase(opBeq, 2, a, a ^ 32'h10, 1'b0);
        branchCase(opBne, 2, a, a ^ 32'h10, 1'b1);
        branchCase(opBne, 2, a, a, 1'b0);
        branchCase(opBlez, 0, -32'sd5, 0, 1'b1);
        branchCase(opBlez, 0, 32'd7, 0, 1'b0);
        branchCase(opBgtz, 0, 32'd7, 0, 1'b1);
        branchCase(opBgtz, 0, 32'd0, 0, 1'b0);
        branchCase(opRegImm, 0, -32'sd3, 0, 1'b1);  // bltz
        branchCase(opRegImm, 0, 32'd0, 0, 1'b0);
        branchCase(opRegImm, 1, 32'd0, 0, 1'b1);    // bgez
        branchCase(opRegImm, 1, -32'sd1, 0, 1'b0);
        // j over one store
        beginProgram();
        emit({opJ, 26'd3});
        emit(iWord(opSw, 0, 0, 16'h0400));
        emit(32'h0);
        emit(iWord(opSw, 0, 0, 16'h0404));
        runProgram();
        expectStore(32'h404, 32'h0, 12);
        finishCheck();
    endtask

    initial begin
        rst = 1'b1;
        idx = 0;
        testReset();
        testImmediates();
        testRType();
        testLoad();
        testBranches();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
